// File: design/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // one filtered projection sample, two's complement
    typedef logic signed [15:0] sample_t;

    // row sum of one PE
    // 15 samples need 4 guard bits, 8 leaves headroom
    typedef logic signed [23:0] sum_t;

    // scan accumulator and step base, unsigned fixed point
    localparam int ACCU_WIDTH = 16;
    // fraction bits, the integer part is the upper 4
    localparam int ACCU_FRAC = 12;
    typedef logic [ACCU_WIDTH-1:0] accu_t;

    // filtered line memory
    localparam int LINE_DEPTH = 64;
    typedef logic [5:0] addr_t;

endpackage

`default_nettype wire

// File: design/bp_shifter.sv
`timescale 1ns/10ps
`default_nettype none

// sequencer for the fill and shift phases of one row
module bp_shifter
    import bp_pkg::*;
#(
    parameter int NUM_PE      = 4,
    parameter int TAP_SPACING = 4,
    parameter int IMAGE_SIZE  = 16
)
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  fill_kick,
    input  logic  shift_kick,
    input  accu_t accu_base,
    output logic  fill_done,
    output logic  shift_done,
    output logic  mp_kick,
    output logic  mp_shift_en,
    output logic  lb_clear,
    output logic  lb_shift_en,
    output logic  pe_kick,
    output logic  pe_step
);

    // position of the last PE tap in the line buffer
    localparam int LAST_TAP = (NUM_PE - 1) * TAP_SPACING;
    // fill runs LAST_TAP+1 cycles, counter goes LAST_TAP..0
    localparam int FILL_INIT = LAST_TAP;
    // first pixel comes from the fill, so IMAGE_SIZE-1 scan steps
    localparam int SHIFT_INIT = IMAGE_SIZE - 2;
    localparam int CNT_MAX = (FILL_INIT > SHIFT_INIT) ? FILL_INIT : SHIFT_INIT;
    localparam int CNT_W = $clog2(CNT_MAX + 1);

    typedef enum logic [1:0] {
        st_ready,
        st_fill,
        st_filled,
        st_shift
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    accu_t            accu;
    accu_t            accu_next;
    logic             int_change;
    logic             fill_last;
    logic             shift_last;
    logic             shift_kick_q;
    // delay lines, bit 1 is the output
    logic [1:0]       fill_done_sr;
    logic [1:0]       shift_done_sr;
    logic [1:0]       step_sr;
    logic             lb_shift_en_q;

    // wraps on purpose, only the integer boundary matters
    assign accu_next = accu + accu_base;
    assign int_change = accu_next[ACCU_WIDTH-1:ACCU_FRAC] != accu[ACCU_WIDTH-1:ACCU_FRAC];

    // last cycle of each phase
    assign fill_last  = (state == st_fill) && (cnt == '0);
    assign shift_last = (state == st_shift) && (cnt == '0);

    // fill kick clears buffer and rewinds mapper in the same cycle
    assign mp_kick  = fill_kick && (state == st_ready);
    assign lb_clear = fill_kick && (state == st_ready);

    // every fill cycle shifts
    // in a scan step only when the integer part moves
    assign mp_shift_en = (state == st_fill) || ((state == st_shift) && int_change);

    // registered kick doubles as PE clear
    assign pe_kick = shift_kick_q;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= st_ready;
            cnt   <= '0;
            accu  <= '0;
        end
        else
        begin
            case (state)
                st_ready:
                begin
                    if (fill_kick)
                    begin
                        state <= st_fill;
                        cnt   <= CNT_W'(FILL_INIT);
                    end
                end
                st_fill:
                begin
                    if (cnt == '0)
                        state <= st_filled;
                    else
                        cnt <= cnt - 1'b1;
                end
                st_filled:
                begin
                    // start half a step in, shift on pixel boundaries
                    // rather than on pixel centres
                    accu <= accu_base >> 1;
                    if (shift_kick_q)
                    begin
                        state <= st_shift;
                        cnt   <= CNT_W'(SHIFT_INIT);
                    end
                end
                st_shift:
                begin
                    accu <= accu_next;
                    if (cnt == '0)
                        state <= st_ready;
                    else
                        cnt <= cnt - 1'b1;
                end
                default:
                    state <= st_ready;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            shift_kick_q  <= 1'b0;
            lb_shift_en_q <= 1'b0;
            fill_done_sr  <= '0;
            shift_done_sr <= '0;
            step_sr       <= '0;
        end
        else
        begin
            // shift kick only counts once the line is in
            shift_kick_q  <= shift_kick && (state == st_filled);
            // one cycle for the registered memory read
            lb_shift_en_q <= mp_shift_en;
            // two cycles: memory read, then line buffer
            fill_done_sr  <= {fill_done_sr[0], fill_last};
            shift_done_sr <= {shift_done_sr[0], shift_last};
            step_sr       <= {step_sr[0], state == st_shift};
        end
    end

    assign lb_shift_en = lb_shift_en_q;
    assign fill_done   = fill_done_sr[1];
    assign shift_done  = shift_done_sr[1];
    // taps of step k are in the buffer when this is high
    assign pe_step     = step_sr[1];

endmodule

`default_nettype wire

// File: design/bp_filter_mapper.sv
`timescale 1ns/10ps
`default_nettype none

// filtered line store with a sequential read pointer
module bp_filter_mapper
    import bp_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    wr_en,
    input  addr_t   wr_addr,
    input  sample_t wr_data,
    input  logic    mp_kick,
    input  logic    mp_shift_en,
    output sample_t rd_sample
);

    sample_t mem [LINE_DEPTH];
    addr_t   rd_ptr;
    sample_t rd_q;

    // load port, only driven while the engine sits idle
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // rewind at fill start, one step per shift request
    always_ff @(posedge clk)
    begin
        if (reset_n)
            rd_ptr <= '0;
        else if (mp_kick)
            rd_ptr <= '0;
        else if (mp_shift_en)
            rd_ptr <= rd_ptr + 1'b1;
    end

    // registered read
    // sample at the current pointer shows up next cycle
    always_ff @(posedge clk)
    begin
        rd_q <= mem[rd_ptr];
    end

    assign rd_sample = rd_q;

endmodule

`default_nettype wire

// File: design/bp_line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

// tapped sample shift register between mapper and PEs
module bp_line_buffer
    import bp_pkg::*;
#(
    parameter int NUM_PE      = 4,
    parameter int TAP_SPACING = 4
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 lb_clear,
    input  logic                 lb_shift_en,
    input  sample_t              rd_sample,
    output sample_t [NUM_PE-1:0] taps
);

    localparam int LAST_TAP = (NUM_PE - 1) * TAP_SPACING;

    // position 0 holds the newest sample
    sample_t line [LAST_TAP+1];

    always_ff @(posedge clk)
    begin
        if (reset_n || lb_clear)
        begin
            for (int i = 0; i <= LAST_TAP; i++)
                line[i] <= '0;
        end
        else if (lb_shift_en)
        begin
            line[0] <= rd_sample;
            for (int i = 1; i <= LAST_TAP; i++)
                line[i] <= line[i-1];
        end
    end

    // taps come straight off the register stages
    // after a full fill tap i holds sample LAST_TAP - i*TAP_SPACING
    always_comb
    begin
        for (int i = 0; i < NUM_PE; i++)
            taps[i] = line[i*TAP_SPACING];
    end

endmodule

`default_nettype wire

// File: design/bp_pe_array.sv
`timescale 1ns/10ps
`default_nettype none

// one accumulator per tap, summed over a scan row
module bp_pe_array
    import bp_pkg::*;
#(
    parameter int NUM_PE     = 4,
    parameter int IMAGE_SIZE = 16
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 pe_kick,
    input  logic                 pe_step,
    input  sample_t [NUM_PE-1:0] taps,
    output sum_t    [NUM_PE-1:0] pe_sums,
    output logic                 result_valid
);

    // scan steps in one row
    localparam int ROW_STEPS = IMAGE_SIZE - 1;
    localparam int STEP_W = $clog2(ROW_STEPS + 1);

    sum_t [NUM_PE-1:0] acc;
    sum_t [NUM_PE-1:0] acc_next;
    sum_t [NUM_PE-1:0] sums_q;
    logic [STEP_W-1:0] step_cnt;
    logic              last_step;
    logic              valid_q;

    // this pe_step is the final one of the row
    assign last_step = pe_step && (step_cnt == STEP_W'(ROW_STEPS - 1));

    always_comb
    begin
        for (int i = 0; i < NUM_PE; i++)
            acc_next[i] = acc[i] + sum_t'(signed'(taps[i]));
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            step_cnt <= '0;
            valid_q  <= 1'b0;
        end
        else
        begin
            // strobe lands as pe_step falls
            valid_q <= last_step;
            if (pe_kick)
                step_cnt <= '0;
            else if (pe_step)
                step_cnt <= step_cnt + 1'b1;
        end
    end

    // running sums, cleared at the start of each row
    always_ff @(posedge clk)
    begin
        if (pe_kick)
            acc <= '0;
        else if (pe_step)
            acc <= acc_next;
    end

    // output sums hold until the next row completes
    always_ff @(posedge clk)
    begin
        if (reset_n)
            sums_q <= '0;
        else if (last_step)
            sums_q <= acc_next;
    end

    assign pe_sums      = sums_q;
    assign result_valid = valid_q;

endmodule

`default_nettype wire

// File: design/bp_top.sv
`timescale 1ns/10ps
`default_nettype none

// row shifting datapath
// shifter drives mapper, line buffer and PE array
module bp_top
    import bp_pkg::*;
#(
    parameter int NUM_PE      = 4,
    parameter int TAP_SPACING = 4,
    parameter int IMAGE_SIZE  = 16
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              fill_kick,
    input  logic              shift_kick,
    input  accu_t             accu_base,
    input  logic              wr_en,
    input  addr_t             wr_addr,
    input  sample_t           wr_data,
    output logic              fill_done,
    output logic              shift_done,
    output logic              result_valid,
    output sum_t [NUM_PE-1:0] pe_sums
);

    // shifter to mapper
    logic mp_kick;
    logic mp_shift_en;
    // shifter to line buffer
    logic lb_clear;
    logic lb_shift_en;
    // shifter to PEs
    logic pe_kick;
    logic pe_step;
    // datapath
    sample_t              rd_sample;
    sample_t [NUM_PE-1:0] taps;

    bp_shifter #(
        .NUM_PE      (NUM_PE),
        .TAP_SPACING (TAP_SPACING),
        .IMAGE_SIZE  (IMAGE_SIZE)
    ) bp_shifter_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .fill_kick   (fill_kick),
        .shift_kick  (shift_kick),
        .accu_base   (accu_base),
        .fill_done   (fill_done),
        .shift_done  (shift_done),
        .mp_kick     (mp_kick),
        .mp_shift_en (mp_shift_en),
        .lb_clear    (lb_clear),
        .lb_shift_en (lb_shift_en),
        .pe_kick     (pe_kick),
        .pe_step     (pe_step)
    );

    bp_filter_mapper bp_filter_mapper_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .mp_kick     (mp_kick),
        .mp_shift_en (mp_shift_en),
        .rd_sample   (rd_sample)
    );

    bp_line_buffer #(
        .NUM_PE      (NUM_PE),
        .TAP_SPACING (TAP_SPACING)
    ) bp_line_buffer_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .lb_clear    (lb_clear),
        .lb_shift_en (lb_shift_en),
        .rd_sample   (rd_sample),
        .taps        (taps)
    );

    bp_pe_array #(
        .NUM_PE       (NUM_PE),
        .IMAGE_SIZE   (IMAGE_SIZE)
    ) bp_pe_array_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .pe_kick      (pe_kick),
        .pe_step      (pe_step),
        .taps         (taps),
        .pe_sums      (pe_sums),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// File: verification/bp_props.sv
`timescale 1ns/10ps
`default_nettype none

// strobe protocol of the shifter
module bp_props
(
    input logic clk,
    input logic reset_n,
    input logic fill_done,
    input logic shift_done,
    input logic mp_shift_en,
    input logic lb_shift_en,
    input logic pe_step,
    input logic in_shift
);

    // count of failed checks, picked up at end of run
    int fail_cnt = 0;

    // done strobes last a single cycle
    fill_done_pulse: assert property (
        @(posedge clk) disable iff (reset_n) fill_done |=> !fill_done)
    else
    begin
        fail_cnt++;
        $error("fill_done high for more than one cycle");
    end

    shift_done_pulse: assert property (
        @(posedge clk) disable iff (reset_n) shift_done |=> !shift_done)
    else
    begin
        fail_cnt++;
        $error("shift_done high for more than one cycle");
    end

    // buffer shift lines up with the registered memory read
    lb_follows_mp: assert property (
        @(posedge clk) disable iff (reset_n) lb_shift_en == $past(mp_shift_en))
    else
    begin
        fail_cnt++;
        $error("lb_shift_en is not mp_shift_en one cycle late");
    end

    // pe_step trails the shift state by two cycles
    step_in_shift: assert property (
        @(posedge clk) disable iff (reset_n) pe_step |-> $past(in_shift, 2))
    else
    begin
        fail_cnt++;
        $error("pe_step outside a shift phase");
    end

endmodule

bind bp_shifter bp_props bp_props_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .fill_done   (fill_done),
    .shift_done  (shift_done),
    .mp_shift_en (mp_shift_en),
    .lb_shift_en (lb_shift_en),
    .pe_step     (pe_step),
    .in_shift    (state == st_shift)
);

`default_nettype wire

// File: verification/bp_tb.sv
`timescale 1ns/10ps
`default_nettype none

// testbench for the row shifting datapath
module bp_tb
    import bp_pkg::*;
();

    localparam int NUM_PE = 4;
    localparam int LINE_LEN = 28;
    // 13 fill cycles, then memory read and buffer stage
    localparam int FILL_LAT = 15;
    // kick register, 15 scan steps, two cycle done delay
    localparam int SHIFT_LAT = 18;
    // one cycle after the last pe_step
    localparam int VALID_LAT = 19;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_TEST = 80;
    localparam int IDLE_CYCLES = 24;

    logic                 clk;
    logic                 reset_n;
    logic                 fill_kick;
    logic                 shift_kick;
    accu_t                accu_base;
    logic                 wr_en;
    addr_t                wr_addr;
    sample_t              wr_data;
    logic                 fill_done;
    logic                 shift_done;
    logic                 result_valid;
    sum_t    [NUM_PE-1:0] pe_sums;
    // outputs as seen at the last falling edge
    logic                 fill_s;
    logic                 shift_s;
    logic                 valid_s;
    sum_t    [NUM_PE-1:0] sums_s;
    // per test: base, 28 samples, 4 sums
    accu_t                base_q [$];
    sample_t              line_q [$];
    sum_t                 exp_q [$];
    int                   errors;
    int                   test_errors;
    int                   tests_run;
    int                   tests_failed;
    logic                 loaded;

    bp_top #(
        .NUM_PE       (NUM_PE),
        .TAP_SPACING  (4),
        .IMAGE_SIZE   (16)
    ) bp_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_kick    (fill_kick),
        .shift_kick   (shift_kick),
        .accu_base    (accu_base),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .fill_done    (fill_done),
        .shift_done   (shift_done),
        .result_valid (result_valid),
        .pe_sums      (pe_sums)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    task automatic check_sum(input string name, input sum_t expected, input sum_t actual);
        if (actual !== expected)
        begin
            errors++;
            test_errors++;
            $display("Error at %0d ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_strobe(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            errors++;
            test_errors++;
            $display("Error at %0d ns: %s expected %b, got %b (strobe %s)",
                     $time, name, expected, actual, expected ? "missing" : "extra");
        end
    endtask

    // sample mid cycle, compare strobes, return on the next rising edge
    task automatic tick(input logic exp_fill, input logic exp_shift, input logic exp_valid);
        @(negedge clk);
        fill_s  = fill_done;
        shift_s = shift_done;
        valid_s = result_valid;
        sums_s  = pe_sums;
        check_strobe("fill_done", exp_fill, fill_s);
        check_strobe("shift_done", exp_shift, shift_s);
        check_strobe("result_valid", exp_valid, valid_s);
        @(posedge clk);
    endtask

    task automatic read_stim();
        int    fd;
        int    code;
        string text;
        int    b;
        int    e [4];
        int    s [14];
        fd = $fopen("verification/bp_stim.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("cannot open verification/bp_stim.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fgets(text, fd);
                // lines starting with # are skipped
                if (code > 0 && text.getc(0) == "t")
                begin
                    code = $sscanf(text, "t %h %d %d %d %d", b, e[0], e[1], e[2], e[3]);
                    base_q.push_back(accu_t'(b));
                    for (int i = 0; i < NUM_PE; i++)
                        exp_q.push_back(sum_t'(e[i]));
                end
                else if (code > 0 && text.getc(0) == "s")
                begin
                    code = $sscanf(text, "s %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                                   s[0], s[1], s[2], s[3], s[4], s[5], s[6],
                                   s[7], s[8], s[9], s[10], s[11], s[12], s[13]);
                    for (int i = 0; i < 14; i++)
                        line_q.push_back(sample_t'(s[i]));
                end
            end
            $fclose(fd);
        end
        if (base_q.size() == 0 || line_q.size() != base_q.size() * LINE_LEN)
        begin
            errors++;
            $display("stim file gives %0d samples for %0d tests", line_q.size(), base_q.size());
        end
    endtask

    task automatic load_line(input int t);
        for (int j = 0; j < LINE_LEN; j++)
        begin
            wr_en   <= 1'b1;
            wr_addr <= addr_t'(j);
            wr_data <= line_q[t*LINE_LEN + j];
            tick(1'b0, 1'b0, 1'b0);
        end
        wr_en <= 1'b0;
    endtask

    task automatic run_fill();
        int lat;
        lat = 0;
        fill_kick <= 1'b1;
        tick(1'b0, 1'b0, 1'b0);
        fill_kick <= 1'b0;
        while (!fill_s && lat < FILL_LAT + 8)
        begin
            lat++;
            tick(lat == FILL_LAT, 1'b0, 1'b0);
        end
        if (!fill_s)
        begin
            errors++;
            test_errors++;
            $display("fill_done never came within %0d cycles of fill_kick", lat);
        end
    endtask

    task automatic run_shift(input int t);
        int lat;
        lat = 0;
        shift_kick <= 1'b1;
        tick(1'b0, 1'b0, 1'b0);
        shift_kick <= 1'b0;
        while (!valid_s && lat < VALID_LAT + 8)
        begin
            lat++;
            tick(1'b0, lat == SHIFT_LAT, lat == VALID_LAT);
        end
        if (!valid_s)
        begin
            errors++;
            test_errors++;
            $display("result_valid never came within %0d cycles of shift_kick", lat);
        end
        else
        begin
            for (int i = 0; i < NUM_PE; i++)
                check_sum($sformatf("pe_sums[%0d]", i), exp_q[t*NUM_PE + i], sums_s[i]);
        end
    endtask

    // shift_kick outside the filled state, nothing may move
    task automatic idle_kick(input sum_t [NUM_PE-1:0] held);
        shift_kick <= 1'b1;
        tick(1'b0, 1'b0, 1'b0);
        shift_kick <= 1'b0;
        repeat (IDLE_CYCLES)
            tick(1'b0, 1'b0, 1'b0);
        for (int i = 0; i < NUM_PE; i++)
            check_sum($sformatf("pe_sums[%0d]", i), held[i], sums_s[i]);
    endtask

    task automatic report_test(input string what);
        tests_run++;
        if (test_errors == 0)
            $display("test %0d, %s: passed", tests_run, what);
        else
        begin
            tests_failed++;
            $display("test %0d, %s: failed with %0d errors", tests_run, what, test_errors);
        end
        test_errors = 0;
    endtask

    // run limit scales with the number of tests
    initial
    begin
        wait (loaded);
        repeat (RESET_CYCLES + CYCLES_PER_TEST * (base_q.size() + 2))
            @(posedge clk);
        $display("watchdog expired after %0d tests, run did not finish", tests_run);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        sum_t [NUM_PE-1:0] held;
        int                last;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        loaded       = 1'b0;
        reset_n      = 1'b1;
        fill_kick    = 1'b0;
        shift_kick   = 1'b0;
        accu_base    = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        read_stim();
        test_errors = 0;
        loaded = 1'b1;
        repeat (RESET_CYCLES)
            @(posedge clk);
        reset_n <= 1'b0;
        // no line loaded yet, sums still at reset
        held = '0;
        idle_kick(held);
        report_test("shift_kick before fill");
        for (int t = 0; t < base_q.size(); t++)
        begin
            load_line(t);
            // base stays put through fill and shift
            accu_base <= base_q[t];
            run_fill();
            run_shift(t);
            report_test($sformatf("accu_base 0x%04h", base_q[t]));
        end
        if (base_q.size() > 0)
        begin
            last = base_q.size() - 1;
            for (int i = 0; i < NUM_PE; i++)
                held[i] = exp_q[last*NUM_PE + i];
            idle_kick(held);
            report_test("shift_kick after row, sums held");
        end
        errors += bp_top_i.bp_shifter_i.bp_props_i.fail_cnt;
        $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_run - tests_failed, tests_failed, errors,
                 bp_top_i.bp_shifter_i.bp_props_i.fail_cnt);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/bp_stim.txt
# t <accu_base hex> <expected pe_sums 0..3, decimal>
# s <14 line samples, decimal>, two s lines per test give samples 0..27
# base 0, line never advances
t 0000 -210 -390 -570 -750
s -50 -47 -44 -41 -38 -35 -32 -29 -26 -23 -20 -17 -14 -11
s -8 -5 -2 1 4 7 10 13 16 19 22 25 28 31
# base 1.0, one sample per step
t 1000 900 1320 1740 2160
s 200 193 186 179 172 165 158 151 144 137 130 123 116 109
s 102 95 88 81 74 67 60 53 46 39 32 25 18 11
# base 0.5, shift on odd steps
t 0800 -12404 -13064 -13724 -14384
s -1000 -989 -978 -967 -956 -945 -934 -923 -912 -901 -890 -879 -868 -857
s -846 -835 -824 -813 -802 -791 -780 -769 -758 -747 -736 -725 -714 -703
# base 0.3, shift on steps 2 6 9 12
t 04cd 5555 5255 4955 4655
s 300 305 310 315 320 325 330 335 340 345 350 355 360 365
s 370 375 380 385 390 395 400 405 410 415 420 425 430 435
# base 1.0, wide samples
t 1000 15000 -45000 -105000 -165000
s -19000 -18000 -17000 -16000 -15000 -14000 -13000 -12000 -11000 -10000 -9000 -8000 -7000 -6000
s -5000 -4000 -3000 -2000 -1000 0 1000 2000 3000 4000 5000 6000 7000 8000

// File: verilog.f
design/bp_pkg.sv
design/bp_shifter.sv
design/bp_filter_mapper.sv
design/bp_line_buffer.sv
design/bp_pe_array.sv
design/bp_top.sv
verification/bp_props.sv
verification/bp_tb.sv
